/* hw/sec_subsys_pkg.sv */
// Shared bus types, address map, register offsets and interrupt vectors, imported by every module
package sec_subsys_pkg;

    // ========================================================================
    // Bus
    // ========================================================================
    localparam int AHB_ADDR_W = 32;
    localparam int AHB_DATA_W = 32;

    localparam logic [1:0] HTRANS_IDLE   = 2'd0;
    localparam logic [1:0] HTRANS_NONSEQ = 2'd2;
    localparam logic       HRESP_OKAY    = 1'b0;
    localparam logic       HRESP_ERROR   = 1'b1;

    // Address phase, one per responder
    typedef struct packed {
        logic [AHB_ADDR_W-1:0] haddr;
        logic [1:0]            htrans;
        logic                  hwrite;
        logic [2:0]            hsize;
        logic                  hsel;
    } ahb_req_t;

    typedef struct packed {
        logic [AHB_DATA_W-1:0] hrdata;
        logic                  hreadyout;
        logic                  hresp;
    } ahb_rsp_t;

    // ========================================================================
    // Address map
    // ========================================================================
    typedef enum logic [1:0] {
        RESP_DOE     = 2'd0,
        RESP_SOC_IFC = 2'd1,
        RESP_ICCM    = 2'd2
    } resp_idx_e;

    localparam int NUM_RESP = 3;
    localparam int OFFSET_W = 8;

    // Indexed by resp_idx_e
    localparam logic [NUM_RESP-1:0][AHB_ADDR_W-1:0] RESP_BASE = {
        32'h4000_0000,   // ICCM
        32'h3003_0000,   // SoC interface
        32'h1000_0000    // DOE
    };
    localparam logic [NUM_RESP-1:0][AHB_ADDR_W-1:0] RESP_MASK = {NUM_RESP{32'h0000_00FF}};

    // ========================================================================
    // DOE
    // ========================================================================
    localparam int KEY_WORDS = 8;
    localparam logic [OFFSET_W-1:0] DOE_DATA_OFS   = 8'h00;
    localparam logic [OFFSET_W-1:0] DOE_STATUS_OFS = 8'h20;   // Bit 0 error, bit 1 notify

    // Used whenever the part is not debug locked
    localparam logic [KEY_WORDS-1:0][AHB_DATA_W-1:0] DEBUG_OBF_KEY = {
        32'hD0E0_0007, 32'hD0E0_0006, 32'hD0E0_0005, 32'hD0E0_0004,
        32'hD0E0_0003, 32'hD0E0_0002, 32'hD0E0_0001, 32'hD0E0_0000
    };

    // SoC interface register offsets
    localparam logic [OFFSET_W-1:0] SOC_GENERIC_OUT_OFS = 8'h00;
    localparam logic [OFFSET_W-1:0] SOC_ICCM_LOCK_OFS   = 8'h04;
    localparam logic [OFFSET_W-1:0] SOC_INTR_STATUS_OFS = 8'h08;
    localparam logic [OFFSET_W-1:0] SOC_INTR_TRIG_OFS   = 8'h0C;
    localparam logic [OFFSET_W-1:0] SOC_CLEAR_OBF_OFS   = 8'h10;
    localparam logic [OFFSET_W-1:0] SOC_BLOCKED_CNT_OFS = 8'h14;
    localparam logic [OFFSET_W-1:0] SOC_GENERIC_IN_OFS  = 8'h18;

    // Interrupt vectors, vector 0 is reserved so bit = vector - 1
    localparam int INTR_VEC_DOE_ERROR = 1;
    localparam int INTR_VEC_DOE_NOTIF = 2;
    localparam int INTR_VEC_SOC_ERROR = 3;
    localparam int INTR_VEC_SOC_NOTIF = 4;
    localparam int NUM_INTR           = 4;

endpackage

/* hw/ahb_lite_fabric.sv */
// Single-initiator AHB-Lite fabric: decodes, blocks disabled responders and muxes responses back
`timescale 1ns/1ns
module ahb_lite_fabric (
    input  logic                                                     clk,
    input  logic                                                     rst_i,
    input  sec_subsys_pkg::ahb_req_t                                 init_req_i,
    input  logic [sec_subsys_pkg::AHB_DATA_W-1:0]                    hwdata_i,
    input  logic [sec_subsys_pkg::NUM_RESP-1:0]                      resp_disable_i,
    input  sec_subsys_pkg::ahb_rsp_t [sec_subsys_pkg::NUM_RESP-1:0]  resp_rsp_i,
    output sec_subsys_pkg::ahb_req_t [sec_subsys_pkg::NUM_RESP-1:0]  resp_req_o,
    output logic [sec_subsys_pkg::AHB_DATA_W-1:0]                    resp_hwdata_o,
    output logic [sec_subsys_pkg::AHB_DATA_W-1:0]                    hrdata_o,
    output logic                                                     hready_o,
    output logic                                                     hresp_o,
    output logic                                                     access_blocked_o
);
    import sec_subsys_pkg::*;

    logic                addr_valid;    // Address phase accepted this cycle
    logic [NUM_RESP-1:0] hit;
    logic [NUM_RESP-1:0] grant;
    logic                hit_any;
    logic                blocked_any;
    resp_idx_e           sel_idx;

    logic      data_valid_q;            // A responder owns the data phase
    resp_idx_e data_sel_q;
    logic      err_first_q;             // Error response, wait cycle
    logic      err_second_q;            // Error response, final cycle

    // ========================================================================
    // Address phase decode
    // ========================================================================
    assign addr_valid = (init_req_i.htrans == HTRANS_NONSEQ) && hready_o;

    always_comb begin
        hit     = '0;
        sel_idx = RESP_DOE;
        for (int i = 0; i < NUM_RESP; i++) begin
            if ((init_req_i.haddr & ~RESP_MASK[i]) == RESP_BASE[i]) begin
                hit[i]  = 1'b1;
                sel_idx = resp_idx_e'(i);
            end
        end
    end

    assign hit_any          = |hit;
    assign blocked_any      = |(hit & resp_disable_i);
    assign grant            = addr_valid ? (hit & ~resp_disable_i) : '0;
    assign access_blocked_o = addr_valid && blocked_any;

    // Only the granted responder sees a live transfer
    always_comb begin
        for (int i = 0; i < NUM_RESP; i++) begin
            resp_req_o[i]        = init_req_i;
            resp_req_o[i].hsel   = grant[i];
            resp_req_o[i].htrans = grant[i] ? init_req_i.htrans : HTRANS_IDLE;
        end
    end

    assign resp_hwdata_o = hwdata_i;

    // ========================================================================
    // Data phase tracking
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            data_valid_q <= 1'b0;
            data_sel_q   <= RESP_DOE;
            err_first_q  <= 1'b0;
            err_second_q <= 1'b0;
        end else begin
            err_first_q  <= addr_valid && (!hit_any || blocked_any);
            err_second_q <= err_first_q;
            if (hready_o) begin
                data_valid_q <= |grant;
                data_sel_q   <= sel_idx;
            end
        end
    end

    // Response mux, fabric error takes precedence
    always_comb begin
        hrdata_o = '0;
        hready_o = 1'b1;
        hresp_o  = HRESP_OKAY;
        if (err_first_q || err_second_q) begin
            hready_o = !err_first_q;
            hresp_o  = HRESP_ERROR;
        end else if (data_valid_q) begin
            hrdata_o = resp_rsp_i[data_sel_q].hrdata;
            hready_o = resp_rsp_i[data_sel_q].hreadyout;
            hresp_o  = resp_rsp_i[data_sel_q].hresp;
        end
    end

endmodule

/* hw/soc_ifc_regs.sv */
// SoC interface registers: generic wires, ICCM lock, secret clear, blocked counter and interrupts
`timescale 1ns/1ns
module soc_ifc_regs (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  sec_subsys_pkg::ahb_req_t              req_i,
    input  logic [sec_subsys_pkg::AHB_DATA_W-1:0] hwdata_i,
    input  logic                                  access_blocked_i,
    input  logic [sec_subsys_pkg::AHB_DATA_W-1:0] generic_input_i,
    output sec_subsys_pkg::ahb_rsp_t              rsp_o,
    output logic [sec_subsys_pkg::AHB_DATA_W-1:0] generic_output_o,
    output logic                                  iccm_lock_o,
    output logic                                  clear_obf_o,
    output logic                                  error_intr_o,
    output logic                                  notif_intr_o
);
    import sec_subsys_pkg::*;

    logic                  acc_valid_q;
    logic                  acc_write_q;
    logic [OFFSET_W-1:0]   acc_ofs_q;
    logic                  wr_en;
    logic [1:0]            intr_sts_q;      // Bit 0 error, bit 1 notify
    logic [7:0]            blocked_cnt_q;
    logic [AHB_DATA_W-1:0] rdata;

    // Address phase capture
    always_ff @(posedge clk) begin
        if (rst_i) begin
            acc_valid_q <= 1'b0;
            acc_write_q <= 1'b0;
            acc_ofs_q   <= '0;
        end else begin
            acc_valid_q <= req_i.hsel && (req_i.htrans == HTRANS_NONSEQ);
            acc_write_q <= req_i.hwrite;
            acc_ofs_q   <= req_i.haddr[OFFSET_W-1:0];
        end
    end

    assign wr_en = acc_valid_q && acc_write_q;

    // ========================================================================
    // Register writes
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            generic_output_o <= '0;
            iccm_lock_o      <= 1'b0;
            clear_obf_o      <= 1'b0;
            intr_sts_q       <= '0;
            blocked_cnt_q    <= '0;
        end else begin
            if (wr_en) begin
                case (acc_ofs_q)
                    SOC_GENERIC_OUT_OFS: generic_output_o <= hwdata_i;
                    SOC_ICCM_LOCK_OFS:   iccm_lock_o      <= iccm_lock_o | hwdata_i[0];
                    SOC_INTR_STATUS_OFS: intr_sts_q       <= intr_sts_q & ~hwdata_i[1:0];
                    SOC_INTR_TRIG_OFS:   intr_sts_q[1]    <= intr_sts_q[1] | hwdata_i[1];
                    SOC_CLEAR_OBF_OFS:   clear_obf_o      <= clear_obf_o | hwdata_i[0];
                    default: ;
                endcase
            end
            if (access_blocked_i) begin
                intr_sts_q[0] <= 1'b1;      // Wins over a same-cycle clear
                if (blocked_cnt_q != 8'hFF) begin
                    blocked_cnt_q <= blocked_cnt_q + 8'd1;
                end
            end
        end
    end

    // Read mux, data valid in the data phase
    always_comb begin
        rdata = '0;
        if (acc_valid_q && !acc_write_q) begin
            case (acc_ofs_q)
                SOC_GENERIC_OUT_OFS: rdata = generic_output_o;
                SOC_ICCM_LOCK_OFS:   rdata = AHB_DATA_W'(iccm_lock_o);
                SOC_INTR_STATUS_OFS: rdata = AHB_DATA_W'(intr_sts_q);
                SOC_CLEAR_OBF_OFS:   rdata = AHB_DATA_W'(clear_obf_o);
                SOC_BLOCKED_CNT_OFS: rdata = AHB_DATA_W'(blocked_cnt_q);
                SOC_GENERIC_IN_OFS:  rdata = generic_input_i;
                default:             rdata = '0;
            endcase
        end
    end

    assign rsp_o.hrdata    = rdata;
    assign rsp_o.hreadyout = 1'b1;   // Zero wait states
    assign rsp_o.hresp     = HRESP_OKAY;

    assign error_intr_o = intr_sts_q[0];
    assign notif_intr_o = intr_sts_q[1];

endmodule

/* hw/doe_unit.sv */
// Obfuscation unit: stores bus words XORed with the selected key and raises status interrupts
`timescale 1ns/1ns
module doe_unit (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  sec_subsys_pkg::ahb_req_t              req_i,
    input  logic [sec_subsys_pkg::AHB_DATA_W-1:0] hwdata_i,
    input  logic [sec_subsys_pkg::KEY_WORDS-1:0][sec_subsys_pkg::AHB_DATA_W-1:0] obf_key_i,
    input  logic                                  debug_locked_i,
    input  logic                                  clear_obf_i,
    output sec_subsys_pkg::ahb_rsp_t              rsp_o,
    output logic                                  error_intr_o,
    output logic                                  notif_intr_o
);
    import sec_subsys_pkg::*;

    localparam int KEY_IDX_W = $clog2(KEY_WORDS);

    logic                                 acc_valid_q;
    logic                                 acc_write_q;
    logic [OFFSET_W-1:0]                  acc_ofs_q;
    logic [OFFSET_W-1:0]                  data_ofs;     // Offset inside the data window
    logic [KEY_IDX_W-1:0]                 word_idx;
    logic                                 is_data;
    logic                                 is_status;
    logic [KEY_WORDS-1:0][AHB_DATA_W-1:0] active_key;
    logic [AHB_DATA_W-1:0]                store_q [KEY_WORDS];
    logic [1:0]                           status_q;     // Bit 0 error, bit 1 notify
    logic [AHB_DATA_W-1:0]                rdata;

    // Cleared secrets beat debug key, debug key beats fuse key
    always_comb begin
        if (clear_obf_i) begin
            active_key = '0;
        end else if (!debug_locked_i) begin
            active_key = DEBUG_OBF_KEY;
        end else begin
            active_key = obf_key_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            acc_valid_q <= 1'b0;
            acc_write_q <= 1'b0;
            acc_ofs_q   <= '0;
        end else begin
            acc_valid_q <= req_i.hsel && (req_i.htrans == HTRANS_NONSEQ);
            acc_write_q <= req_i.hwrite;
            acc_ofs_q   <= req_i.haddr[OFFSET_W-1:0];
        end
    end

    assign data_ofs  = acc_ofs_q - DOE_DATA_OFS;
    assign word_idx  = data_ofs[KEY_IDX_W+1:2];
    assign is_data   = (data_ofs < OFFSET_W'(4 * KEY_WORDS)) && (data_ofs[1:0] == 2'b00);
    assign is_status = (acc_ofs_q == DOE_STATUS_OFS);

    // Obfuscated store
    always_ff @(posedge clk) begin
        if (acc_valid_q && acc_write_q && is_data) begin
            store_q[word_idx] <= hwdata_i ^ active_key[word_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            status_q <= '0;
        end else if (acc_valid_q) begin
            if (!is_data && !is_status) begin
                status_q[0] <= 1'b1;                     // Bad offset
            end else if (acc_write_q && is_status) begin
                status_q <= status_q & ~hwdata_i[1:0];   // Write 1 to clear
            end else if (acc_write_q) begin
                status_q[1] <= 1'b1;
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (acc_valid_q && !acc_write_q) begin
            if (is_data) begin
                rdata = store_q[word_idx];
            end else if (is_status) begin
                rdata = AHB_DATA_W'(status_q);
            end
        end
    end

    assign rsp_o.hrdata    = rdata;
    assign rsp_o.hreadyout = 1'b1;
    assign rsp_o.hresp     = HRESP_OKAY;   // Bad offsets still answer OKAY

    assign error_intr_o = status_q[0];
    assign notif_intr_o = status_q[1];

endmodule

/* hw/iccm_mem.sv */
// Zero-wait-state instruction memory behind the fabric, contents kept across reset
`timescale 1ns/1ns
module iccm_mem #(
    parameter int ICCM_DEPTH = 64
) (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  sec_subsys_pkg::ahb_req_t              req_i,
    input  logic [sec_subsys_pkg::AHB_DATA_W-1:0] hwdata_i,
    output sec_subsys_pkg::ahb_rsp_t              rsp_o
);
    import sec_subsys_pkg::*;

    localparam int IDX_W = $clog2(ICCM_DEPTH);

    logic                  acc_valid_q;
    logic                  acc_write_q;
    logic [IDX_W-1:0]      acc_idx_q;   // Word index from the address phase
    logic [AHB_DATA_W-1:0] mem [ICCM_DEPTH];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            acc_valid_q <= 1'b0;
            acc_write_q <= 1'b0;
            acc_idx_q   <= '0;
        end else begin
            acc_valid_q <= req_i.hsel && (req_i.htrans == HTRANS_NONSEQ);
            acc_write_q <= req_i.hwrite;
            acc_idx_q   <= req_i.haddr[IDX_W+1:2];
        end
    end

    // Write lands at the end of the data phase
    always_ff @(posedge clk) begin
        if (acc_valid_q && acc_write_q) begin
            mem[acc_idx_q] <= hwdata_i;
        end
    end

    assign rsp_o.hrdata    = (acc_valid_q && !acc_write_q) ? mem[acc_idx_q] : '0;
    assign rsp_o.hreadyout = 1'b1;
    assign rsp_o.hresp     = HRESP_OKAY;

endmodule

/* hw/sec_subsys_top.sv */
// Subsystem top: bus fabric, DOE, SoC interface registers, ICCM and the interrupt vector
`timescale 1ns/1ns
module sec_subsys_top #(
    parameter int ICCM_DEPTH = 64
) (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  sec_subsys_pkg::ahb_req_t              ahb_req_i,
    input  logic [sec_subsys_pkg::AHB_DATA_W-1:0] hwdata_i,
    input  logic [sec_subsys_pkg::KEY_WORDS-1:0][sec_subsys_pkg::AHB_DATA_W-1:0] obf_key_i,
    input  logic                                  debug_locked_i,
    input  logic [sec_subsys_pkg::AHB_DATA_W-1:0] generic_input_i,
    output logic [sec_subsys_pkg::AHB_DATA_W-1:0] hrdata_o,
    output logic                                  hready_o,
    output logic                                  hresp_o,
    output logic [sec_subsys_pkg::AHB_DATA_W-1:0] generic_output_o,
    output logic [sec_subsys_pkg::NUM_INTR-1:0]   intr_o
);
    import sec_subsys_pkg::*;

    ahb_req_t [NUM_RESP-1:0] resp_req;
    ahb_rsp_t [NUM_RESP-1:0] resp_rsp;
    logic [AHB_DATA_W-1:0]   resp_hwdata;
    logic [NUM_RESP-1:0]     resp_disable;
    logic                    iccm_lock;
    logic                    access_blocked;
    logic                    clear_obf;
    logic                    doe_error_intr;
    logic                    doe_notif_intr;
    logic                    soc_error_intr;
    logic                    soc_notif_intr;

    // ========================================================================
    // Fabric
    // ========================================================================
    always_comb begin
        resp_disable            = '0;
        resp_disable[RESP_ICCM] = iccm_lock;   // Locked ICCM is off the bus
    end

    ahb_lite_fabric u_fabric (
        .clk              (clk),
        .rst_i            (rst_i),
        .init_req_i       (ahb_req_i),
        .hwdata_i         (hwdata_i),
        .resp_disable_i   (resp_disable),
        .resp_rsp_i       (resp_rsp),
        .resp_req_o       (resp_req),
        .resp_hwdata_o    (resp_hwdata),
        .hrdata_o         (hrdata_o),
        .hready_o         (hready_o),
        .hresp_o          (hresp_o),
        .access_blocked_o (access_blocked)
    );

    // ========================================================================
    // Responders
    // ========================================================================
    soc_ifc_regs u_soc_ifc (
        .clk              (clk),
        .rst_i            (rst_i),
        .req_i            (resp_req[RESP_SOC_IFC]),
        .hwdata_i         (resp_hwdata),
        .access_blocked_i (access_blocked),
        .generic_input_i  (generic_input_i),
        .rsp_o            (resp_rsp[RESP_SOC_IFC]),
        .generic_output_o (generic_output_o),
        .iccm_lock_o      (iccm_lock),
        .clear_obf_o      (clear_obf),
        .error_intr_o     (soc_error_intr),
        .notif_intr_o     (soc_notif_intr)
    );

    doe_unit u_doe (
        .clk            (clk),
        .rst_i          (rst_i),
        .req_i          (resp_req[RESP_DOE]),
        .hwdata_i       (resp_hwdata),
        .obf_key_i      (obf_key_i),
        .debug_locked_i (debug_locked_i),
        .clear_obf_i    (clear_obf),
        .rsp_o          (resp_rsp[RESP_DOE]),
        .error_intr_o   (doe_error_intr),
        .notif_intr_o   (doe_notif_intr)
    );

    iccm_mem #(
        .ICCM_DEPTH (ICCM_DEPTH)
    ) u_iccm (
        .clk      (clk),
        .rst_i    (rst_i),
        .req_i    (resp_req[RESP_ICCM]),
        .hwdata_i (resp_hwdata),
        .rsp_o    (resp_rsp[RESP_ICCM])
    );

    // Vector 0 is reserved, so each source sits at vector - 1
    always_comb begin
        intr_o                         = '0;
        intr_o[INTR_VEC_DOE_ERROR - 1] = doe_error_intr;
        intr_o[INTR_VEC_DOE_NOTIF - 1] = doe_notif_intr;
        intr_o[INTR_VEC_SOC_ERROR - 1] = soc_error_intr;
        intr_o[INTR_VEC_SOC_NOTIF - 1] = soc_notif_intr;
    end

endmodule

/* verification/tb_sec_subsys.sv */
// Directed testbench top that drives AHB-Lite transfers into the security subsystem and checks them
`timescale 1ns/1ns
module tb_sec_subsys;
    import sec_subsys_pkg::*;

    localparam int          CLK_HALF       = 50;
    localparam int          DRIVE_DLY      = 10;
    localparam int          TIMEOUT_CYCLES = 5000;   // Tests need under 2000
    localparam logic [31:0] SEED           = 32'hdc71c74f;
    localparam logic [31:0] DOE_BASE       = 32'h1000_0000;
    localparam logic [31:0] SOC_BASE       = 32'h3003_0000;
    localparam logic [31:0] ICCM_BASE      = 32'h4000_0000;
    localparam logic [31:0] UNMAPPED_ADDR  = 32'h2000_0000;

    logic                                 clk;
    logic                                 rst;
    ahb_req_t                             ahb_req;
    logic [AHB_DATA_W-1:0]                hwdata;
    logic [KEY_WORDS-1:0][AHB_DATA_W-1:0] obf_key;
    logic                                 debug_locked;
    logic [AHB_DATA_W-1:0]                generic_input;
    logic [AHB_DATA_W-1:0]                hrdata;
    logic                                 hready;
    logic                                 hresp;
    logic [AHB_DATA_W-1:0]                generic_output;
    logic [NUM_INTR-1:0]                  intr;

    int   errors    = 0;
    int   cycle_cnt = 0;
    int   wait_cycles;      // Data-phase cycles with hready_o low
    logic first_resp;       // hresp_o in the first data-phase cycle

    sec_subsys_top #(
        .ICCM_DEPTH (64)
    ) u_sec_subsys_top (
        .clk              (clk),
        .rst_i            (rst),
        .ahb_req_i        (ahb_req),
        .hwdata_i         (hwdata),
        .obf_key_i        (obf_key),
        .debug_locked_i   (debug_locked),
        .generic_input_i  (generic_input),
        .hrdata_o         (hrdata),
        .hready_o         (hready),
        .hresp_o          (hresp),
        .generic_output_o (generic_output),
        .intr_o           (intr)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Run limit
    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, tests did not finish, errors: %0d",
                 TIMEOUT_CYCLES, errors);
        $display("TEST FAIL");
        $finish;
    end

    // ========================================================================
    // Bus tasks
    // ========================================================================
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("ERROR %s: got 0x%08h, expected 0x%08h (cycle %0d)", name, got, exp, cycle_cnt);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
    endtask

    task automatic bus_transfer(input logic is_write, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        ahb_req.haddr  = addr;
        ahb_req.htrans = HTRANS_NONSEQ;
        ahb_req.hwrite = is_write;
        ahb_req.hsize  = 3'd2;   // Word
        ahb_req.hsel   = 1'b1;
        @(posedge clk);          // Address phase accepted here
        #DRIVE_DLY;
        ahb_req.htrans = HTRANS_IDLE;
        hwdata         = wdata;
        wait_cycles    = 0;
        @(negedge clk);
        first_resp = hresp;
        while (!hready) begin
            wait_cycles++;
            @(negedge clk);
        end
        rdata = hrdata;
        err   = hresp;
        @(posedge clk);
        #DRIVE_DLY;
        ahb_req.hsel = 1'b0;
    endtask

    task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused_rdata;
        bus_transfer(1'b1, addr, data, unused_rdata, err);
    endtask

    task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        bus_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic write_okay(input logic [31:0] addr, input logic [31:0] data);
        logic err;
        ahb_write(addr, data, err);
        if (err !== 1'b0) report_mismatch("hresp_o", 32'(err), 32'h0);
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        ahb_read(addr, data, err);
        if (err !== 1'b0) report_mismatch("hresp_o", 32'(err), 32'h0);
        if (data !== exp) report_mismatch("hrdata_o", data, exp);
    endtask

    // Two-cycle error with hresp high in the wait cycle and in the final cycle
    task automatic expect_error_access(input logic is_write, input logic [31:0] addr,
                                       input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        bus_transfer(is_write, addr, data, rdata, err);
        if (first_resp !== 1'b1) report_mismatch("hresp_o first cycle", 32'(first_resp), 32'h1);
        if (wait_cycles != 1) report_mismatch("hready_o low cycles", wait_cycles, 32'h1);
        if (err !== 1'b1) report_mismatch("hresp_o", 32'(err), 32'h1);
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic test_iccm_round_trip();
        logic [5:0]  idx [16];
        logic [31:0] model [64];
        logic [31:0] data;
        for (int i = 0; i < 16; i++) begin
            idx[i]        = 6'($urandom_range(63, 0));
            data          = $urandom();
            model[idx[i]] = data;   // Repeated index keeps the last write
            write_okay(ICCM_BASE | {24'h0, idx[i], 2'b00}, data);
        end
        for (int i = 0; i < 16; i++) begin
            read_check(ICCM_BASE | {24'h0, idx[i], 2'b00}, model[idx[i]]);
        end
    endtask

    task automatic test_unmapped();
        expect_error_access(1'b0, UNMAPPED_ADDR, 32'h0);
        if (hready !== 1'b1) report_mismatch("hready_o", 32'(hready), 32'h1);
        if (intr !== 4'b0000) report_mismatch("intr_o", 32'(intr), 32'h0);   // No source fires
    endtask

    task automatic doe_round_trip(input logic [KEY_WORDS-1:0][31:0] key);
        logic [31:0] data [KEY_WORDS];
        for (int i = 0; i < KEY_WORDS; i++) begin
            data[i] = $urandom();
            write_okay(DOE_BASE + 32'(4 * i), data[i]);
        end
        for (int i = 0; i < KEY_WORDS; i++) begin
            read_check(DOE_BASE + 32'(4 * i), data[i] ^ key[i]);
        end
        if (intr !== 4'b0010) report_mismatch("intr_o", 32'(intr), 32'h2);
        write_okay(DOE_BASE + 32'h20, 32'h2);   // Clear notify
        if (intr !== 4'b0000) report_mismatch("intr_o", 32'(intr), 32'h0);
    endtask

    task automatic test_doe_keys();
        logic [KEY_WORDS-1:0][31:0] debug_key;
        for (int i = 0; i < KEY_WORDS; i++) begin
            debug_key[i] = 32'hD0E0_0000 + 32'(i);
        end
        debug_locked = 1'b1;
        doe_round_trip(obf_key);
        debug_locked = 1'b0;
        doe_round_trip(debug_key);
        write_okay(SOC_BASE + 32'h10, 32'h1);   // Clearing secrets zeroes the key
        doe_round_trip('0);
        read_check(DOE_BASE + 32'h40, 32'h0);   // Bad offset still OKAY
        if (intr !== 4'b0001) report_mismatch("intr_o", 32'(intr), 32'h1);
        write_okay(DOE_BASE + 32'h20, 32'h1);
        if (intr !== 4'b0000) report_mismatch("intr_o", 32'(intr), 32'h0);
        debug_locked = 1'b1;
    endtask

    task automatic test_iccm_lock();
        logic [31:0] keep;
        keep = $urandom();
        write_okay(ICCM_BASE + 32'h14, keep);
        write_okay(SOC_BASE + 32'h04, 32'h1);
        read_check(SOC_BASE + 32'h04, 32'h1);
        expect_error_access(1'b0, ICCM_BASE + 32'h14, 32'h0);
        expect_error_access(1'b1, ICCM_BASE + 32'h14, ~keep);
        write_okay(SOC_BASE + 32'h04, 32'h0);   // Lock is sticky
        read_check(SOC_BASE + 32'h04, 32'h1);
        expect_error_access(1'b0, ICCM_BASE + 32'h80, 32'h0);
        read_check(SOC_BASE + 32'h14, 32'd3);
        if (intr !== 4'b0100) report_mismatch("intr_o", 32'(intr), 32'h4);
        write_okay(SOC_BASE + 32'h08, 32'h1);
        if (intr !== 4'b0000) report_mismatch("intr_o", 32'(intr), 32'h0);
        apply_reset();   // Only reset unlocks and memory contents survive
        read_check(SOC_BASE + 32'h04, 32'h0);
        read_check(SOC_BASE + 32'h14, 32'h0);
        read_check(ICCM_BASE + 32'h14, keep);
    endtask

    task automatic test_generic_notify();
        logic [31:0] value;
        value = $urandom();
        write_okay(SOC_BASE + 32'h00, value);
        if (generic_output !== value) report_mismatch("generic_output_o", generic_output, value);
        read_check(SOC_BASE + 32'h00, value);
        generic_input = $urandom();
        read_check(SOC_BASE + 32'h18, generic_input);
        write_okay(SOC_BASE + 32'h0C, 32'h2);
        if (intr !== 4'b1000) report_mismatch("intr_o", 32'(intr), 32'h8);
        write_okay(SOC_BASE + 32'h08, 32'h2);
        if (intr !== 4'b0000) report_mismatch("intr_o", 32'(intr), 32'h0);
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        rst           = 1'b1;
        ahb_req       = '0;
        hwdata        = '0;
        debug_locked  = 1'b1;
        generic_input = '0;
        void'($urandom(SEED));
        for (int w = 0; w < KEY_WORDS; w++) begin
            obf_key[w] = $urandom();
        end
        apply_reset();
        if (hready !== 1'b1) report_mismatch("hready_o", 32'(hready), 32'h1);
        if (hresp !== 1'b0) report_mismatch("hresp_o", 32'(hresp), 32'h0);
        if (intr !== 4'b0000) report_mismatch("intr_o", 32'(intr), 32'h0);
        if (generic_output !== 32'h0) report_mismatch("generic_output_o", generic_output, 32'h0);

        test_iccm_round_trip();
        test_unmapped();
        test_doe_keys();
        test_iccm_lock();
        test_generic_notify();

        $display("Run complete after %0d cycles, errors: %0d", cycle_cnt, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sec_subsys.f */
hw/sec_subsys_pkg.sv
hw/ahb_lite_fabric.sv
hw/soc_ifc_regs.sv
hw/doe_unit.sv
hw/iccm_mem.sv
hw/sec_subsys_top.sv
verification/tb_sec_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Compile the subsystem and its testbench with Verilator, run, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/1ns \
    --top-module tb_sec_subsys \
    --Mdir obj_dir \
    -f sec_subsys.f

./obj_dir/Vtb_sec_subsys | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
